/* test/fetch_trace.txt */
// kind 1 load: addr data | kind 2 control: after_beat delay event(1 clear 2 misp 3 load) a b c
// kind 3 expect: pc instr abort taken | unused columns zero, kind 0 ends the trace
1 00000000 E3A00000 0 0 0 0
1 00000004 E3A01001 0 0 0 0
1 00000008 E3A02002 0 0 0 0
1 0000000C E3A03003 0 0 0 0
1 00000014 E3A0F0FF 0 0 0 0
1 000003F8 E1A01002 0 0 0 0
1 000003FC E1A02003 0 0 0 0
1 00000040 E2811001 0 0 0 0
1 00000044 EA000002 0 0 0 0
1 00000048 E2822002 0 0 0 0
1 00000054 E2833003 0 0 0 0
2 00000000 0 3 00000010 E3A04004 0
2 00000004 0 1 000003F8 0 0
2 00000007 C 1 00000040 0 0
2 0000000A 0 2 00000044 0 00000040
2 0000000A 0 2 00000044 1 00000040
3 00000000 E3A00000 0 1 0 0
3 00000004 E3A01001 0 1 0 0
3 00000008 E3A02002 0 1 0 0
3 0000000C E3A03003 0 1 0 0
3 00000010 E3A04004 0 1 0 0
3 000003F8 E1A01002 0 1 0 0
3 000003FC E1A02003 0 1 0 0
3 00000400 00000000 1 1 0 0
3 00000040 E2811001 0 1 0 0
3 00000044 EA000002 0 1 0 0
3 00000048 E2822002 0 1 0 0
3 00000040 E2811001 0 1 0 0
3 00000044 EA000002 0 2 0 0
3 00000054 E2833003 0 1 0 0
0 0 0 0 0 0 0

/* list.f */
hw/fetch_pkg.sv
hw/imem_arbiter.sv
hw/imem.sv
hw/pc_gen.sv
hw/branch_predictor.sv
hw/fetch_stage.sv
hw/fetch_top.sv
test/tb_fetch.sv

/* Bender.yml */
package:
  name: fetch_frontend

sources:
  - hw/fetch_pkg.sv
  - hw/imem_arbiter.sv
  - hw/imem.sv
  - hw/pc_gen.sv
  - hw/branch_predictor.sv
  - hw/fetch_stage.sv
  - hw/fetch_top.sv
  - target: test
    files:
      - test/tb_fetch.sv

/* test/tb_fetch.sv */
`timescale 1ns/1ps

module tb_fetch;

        localparam int          REC_W    = 7;            // Words per trace record.
        localparam int          MAX_RECS = 96;
        localparam int          MAX_LIST = 64;
        localparam logic [31:0] K_END    = 32'd0;
        localparam logic [31:0] K_LOAD   = 32'd1;
        localparam logic [31:0] K_CTRL   = 32'd2;
        localparam logic [31:0] K_EXP    = 32'd3;
        localparam logic [31:0] EV_CLEAR = 32'd1;        // Writeback clear.
        localparam logic [31:0] EV_MISP  = 32'd2;        // Execute mispredict.
        localparam logic [31:0] EV_LOAD  = 32'd3;        // Loader write while running.
        localparam logic [31:0] SEED     = 32'hb1bc4079;

        logic        clk;
        logic        reset;
        logic        ld_valid;
        logic [31:0] ld_addr;
        logic [31:0] ld_data;
        logic        ld_ready;
        logic        clear_wb;
        logic [31:0] clear_pc;
        logic        stall;
        logic        bp_confirm;
        logic        bp_mispredict;
        logic [31:0] bp_pc;
        logic [1:0]  bp_state;
        logic [31:0] instruction;
        logic        valid;
        logic        abort;
        logic [31:0] pc;
        logic [31:0] pc_plus_8;
        logic [1:0]  taken;

        logic [31:0] trace_mem [REC_W*MAX_RECS];
        logic [31:0] l_addr [MAX_LIST];  // Preload list.
        logic [31:0] l_data [MAX_LIST];
        logic [31:0] c_idx  [MAX_LIST];  // Fire after this beat index.
        logic [31:0] c_dly  [MAX_LIST];
        logic [31:0] c_evt  [MAX_LIST];
        logic [31:0] c_a    [MAX_LIST];
        logic [31:0] c_b    [MAX_LIST];
        logic [31:0] c_c    [MAX_LIST];
        logic [31:0] e_pc   [MAX_LIST];  // Expected beats, in order.
        logic [31:0] e_ins  [MAX_LIST];
        logic [31:0] e_abt  [MAX_LIST];
        logic [31:0] e_tkn  [MAX_LIST];
        int          n_load;
        int          n_ctrl;
        int          n_exp;
        int          seen;               // Beats checked so far.
        int          errors;
        int          cycles;
        int          limit;
        logic        ld_accepted;        // Loader transfer seen at the last negedge.
        logic        ld_busy;
        logic        held;               // Stage frozen last cycle, beat repeats.

        fetch_top u_dut (.i_clk(clk), .i_reset(reset), .i_ld_valid(ld_valid),
                .i_ld_addr(ld_addr), .i_ld_data(ld_data), .o_ld_ready(ld_ready),
                .i_clear_wb(clear_wb), .i_clear_pc(clear_pc), .i_stall(stall),
                .i_bp_confirm(bp_confirm), .i_bp_mispredict(bp_mispredict),
                .i_bp_pc(bp_pc), .i_bp_state(bp_state), .o_instruction(instruction),
                .o_valid(valid), .o_abort(abort), .o_pc(pc), .o_pc_plus_8(pc_plus_8),
                .o_taken(taken));

        initial
        begin
                clk = 1'b0;
                forever #5 clk = ~clk; // 10 ns period.
        end

        task automatic check_value(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
                assert (got === exp)
                else
                begin
                        errors++;
                        $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
                end
        endtask

        task automatic check_beat(input int k);
                check_value("o_pc", pc, e_pc[k]);
                check_value("o_instruction", instruction, e_ins[k]);
                check_value("o_abort", {31'd0, abort}, e_abt[k]);
                check_value("o_pc_plus_8", pc_plus_8, e_pc[k] + 32'd8); // Always PC+8.
                check_value("o_taken", {30'd0, taken}, e_tkn[k]);
        endtask

        // Split the flat trace into loads, control events and expected beats.
        task automatic parse_trace();
                int          base;
                logic [31:0] kind;
                n_load = 0;
                n_ctrl = 0;
                n_exp  = 0;
                for (int r = 0; r < MAX_RECS; r++)
                begin
                        base = r * REC_W;
                        kind = trace_mem[base];
                        if (kind === K_END)
                                break;
                        if (kind === K_LOAD)
                        begin
                                l_addr[n_load] = trace_mem[base+1];
                                l_data[n_load] = trace_mem[base+2];
                                n_load++;
                        end
                        else if (kind === K_CTRL)
                        begin
                                c_idx[n_ctrl] = trace_mem[base+1];
                                c_dly[n_ctrl] = trace_mem[base+2];
                                c_evt[n_ctrl] = trace_mem[base+3];
                                c_a[n_ctrl]   = trace_mem[base+4];
                                c_b[n_ctrl]   = trace_mem[base+5];
                                c_c[n_ctrl]   = trace_mem[base+6];
                                n_ctrl++;
                        end
                        else if (kind === K_EXP)
                        begin
                                e_pc[n_exp]  = trace_mem[base+1];
                                e_ins[n_exp] = trace_mem[base+2];
                                e_abt[n_exp] = trace_mem[base+3];
                                e_tkn[n_exp] = trace_mem[base+4];
                                n_exp++;
                        end
                        else
                        begin
                                errors++;
                                $display("Trace record %0d has an unknown kind", r);
                                break;
                        end
                end
        endtask

        // One loader write, held until the arbiter takes it.
        task automatic preload_word(input logic [31:0] addr, input logic [31:0] data);
                @(posedge clk);
                ld_valid <= 1'b1;
                ld_addr  <= addr;
                ld_data  <= data;
                do
                        @(posedge clk);
                while (!ld_accepted);
                ld_valid <= 1'b0;
        endtask

        task automatic apply_event(input int ci);
                case (c_evt[ci])
                EV_CLEAR:
                begin
                        clear_wb <= 1'b1;
                        clear_pc <= c_a[ci];
                end
                EV_MISP:
                begin
                        bp_mispredict <= 1'b1;
                        bp_pc         <= c_a[ci];
                        bp_state      <= c_b[ci][1:0]; // State it was predicted with.
                        clear_pc      <= c_c[ci];      // Redirect target.
                end
                EV_LOAD:
                begin
                        ld_valid <= 1'b1;
                        ld_addr  <= c_a[ci];
                        ld_data  <= c_b[ci];
                        ld_busy  = 1'b1;
                end
                default:
                begin
                        errors++;
                        $display("Control record %0d has an unknown event", ci);
                end
                endcase
        endtask

        // Drive events and random stalls until every expected beat is checked.
        task automatic run_stream();
                int   ci;
                int   dly_cnt;
                logic fire;
                ci      = 0;
                dly_cnt = 0;
                while (seen < n_exp)
                begin
                        @(posedge clk);
                        fire = 1'b0;
                        clear_wb      <= 1'b0;
                        bp_mispredict <= 1'b0;
                        if (ld_busy && ld_accepted)
                        begin
                                ld_valid <= 1'b0;
                                ld_busy  = 1'b0;
                        end
                        if (ci < n_ctrl && seen > c_idx[ci])
                        begin
                                if (dly_cnt < c_dly[ci])
                                begin
                                        dly_cnt++;
                                end
                                else
                                begin
                                        fire = 1'b1;
                                        apply_event(ci);
                                        ci++;
                                        dly_cnt = 0;
                                end
                        end
                        stall <= fire ? 1'b0 : ($urandom_range(3) == 0); // Events unstalled.
                end
        endtask

        // Beats sampled mid-cycle, a held beat is not counted twice.
        always @(negedge clk)
        begin
                ld_accepted = ld_valid && ld_ready;
                if (!reset && valid && !held && seen < n_exp)
                begin
                        check_beat(seen);
                        seen++;
                end
                held = stall;
        end

        always @(posedge clk)
        begin
                cycles++;
                if (cycles > limit)
                begin
                        $display("Timeout after %0d cycles, %0d of %0d beats seen",
                                 cycles, seen, n_exp);
                        $display("Beats checked %0d, errors %0d", seen, errors);
                        $display("Result: FAILED");
                        $finish;
                end
        end

        initial
        begin
                reset         = 1'b1;
                ld_valid      = 1'b0;
                ld_addr       = 32'd0;
                ld_data       = 32'd0;
                clear_wb      = 1'b0;
                clear_pc      = 32'd0;
                stall         = 1'b1;  // Fetch frozen while the program loads.
                bp_confirm    = 1'b0;
                bp_mispredict = 1'b0;
                bp_pc         = 32'd0;
                bp_state      = 2'd0;
                seen          = 0;
                errors        = 0;
                cycles        = 0;
                ld_accepted   = 1'b0;
                ld_busy       = 1'b0;
                held          = 1'b0;
                void'($urandom(SEED));
                $readmemh("test/fetch_trace.txt", trace_mem);
                parse_trace();
                limit = 40 * n_exp + 2 * (n_load + n_ctrl) + 4;
                repeat (4) @(posedge clk);
                reset <= 1'b0;
                for (int i = 0; i < n_load; i++)
                        preload_word(l_addr[i], l_data[i]);
                run_stream();
                $display("Beats checked %0d, errors %0d", seen, errors);
                if (errors == 0)
                        $display("Result: PASSED");
                else
                        $display("Result: FAILED");
                $finish;
        end

endmodule

/* hw/fetch_top.sv */
`timescale 1ns/1ps

module fetch_top (
        input  logic        i_clk,
        input  logic        i_reset,
        input  logic        i_ld_valid,      // Program loader.
        input  logic [31:0] i_ld_addr,
        input  logic [31:0] i_ld_data,
        output logic        o_ld_ready,
        input  logic        i_clear_wb,
        input  logic [31:0] i_clear_pc,
        input  logic        i_stall,
        input  logic        i_bp_confirm,
        input  logic        i_bp_mispredict,
        input  logic [31:0] i_bp_pc,
        input  logic [1:0]  i_bp_state,
        output logic [31:0] o_instruction,
        output logic        o_valid,
        output logic        o_abort,
        output logic [31:0] o_pc,
        output logic [31:0] o_pc_plus_8,
        output logic [1:0]  o_taken
);

        logic        f_valid;
        logic        f_ready;
        logic [31:0] f_pc;
        logic        grant_ld;
        logic        mem_en;
        logic [31:0] mem_rdata;
        logic        mem_abort;
        logic        mem_rsp;
        logic        squash_q;   // In-flight fetch is stale.
        logic        rsp_valid;
        logic [1:0]  bp_rd_state;
        logic        clear_any;
        logic        sleep;

        // ALU flush only counts when not frozen.
        assign clear_any = i_clear_wb || (i_bp_mispredict && !i_stall);
        assign mem_en    = (f_valid && f_ready) || (i_ld_valid && o_ld_ready);
        assign rsp_valid = mem_rsp && !squash_q;

        // Kill the one response already requested when a clear lands.
        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                        squash_q <= 1'b0;
                else if (clear_any && f_valid)
                        squash_q <= 1'b1;
                else if (mem_rsp)
                        squash_q <= 1'b0;
        end

        imem_arbiter u_arb (.i_clk(i_clk), .i_reset(i_reset), .i_f_valid(f_valid),
                .o_f_ready(f_ready), .i_l_valid(i_ld_valid), .o_l_ready(o_ld_ready),
                .o_grant_ld(grant_ld));

        imem u_imem (.i_clk(i_clk), .i_reset(i_reset), .i_en(mem_en), .i_we(grant_ld),
                .i_addr(grant_ld ? i_ld_addr : f_pc), .i_wdata(i_ld_data),
                .o_rdata(mem_rdata), .o_abort(mem_abort), .o_rsp_valid(mem_rsp));

        pc_gen u_pc_gen (.i_clk(i_clk), .i_reset(i_reset), .o_req_valid(f_valid),
                .i_req_ready(f_ready), .o_req_pc(f_pc), .i_rsp_valid(rsp_valid),
                .i_rsp_data(mem_rdata), .i_bp_state(bp_rd_state), .i_stall(i_stall),
                .i_clear(clear_any), .i_clear_pc(i_clear_pc), .i_sleep(sleep));

        branch_predictor u_bp (.i_clk(i_clk), .i_reset(i_reset), .i_rd_pc(f_pc),
                .o_state(bp_rd_state), .i_confirm(i_bp_confirm),
                .i_mispredict(i_bp_mispredict), .i_stall(i_stall), .i_upd_pc(i_bp_pc),
                .i_upd_state(i_bp_state));

        fetch_stage u_fetch (.i_clk(i_clk), .i_reset(i_reset), .i_clear_wb(i_clear_wb),
                .i_stall(i_stall), .i_clear_alu(i_bp_mispredict), .i_rsp_valid(rsp_valid),
                .i_instruction(mem_rdata), .i_abort(mem_abort), .i_pc(f_pc),
                .i_bp_state(bp_rd_state), .o_instruction(o_instruction), .o_valid(o_valid),
                .o_abort(o_abort), .o_pc(o_pc), .o_pc_plus_8(o_pc_plus_8),
                .o_taken(o_taken), .o_sleep(sleep));

        // Loader must stay inside the program space.
        a_ld_range : assert property (@(posedge i_clk) disable iff (i_reset)
                i_ld_valid |-> i_ld_addr[31:2] < fetch_pkg::IMEM_DEPTH);

endmodule

/* hw/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage (
        input  logic        i_clk,
        input  logic        i_reset,
        input  logic        i_clear_wb,    // Highest priority.
        input  logic        i_stall,
        input  logic        i_clear_alu,   // Mispredict flush.
        input  logic        i_rsp_valid,
        input  logic [31:0] i_instruction,
        input  logic        i_abort,
        input  logic [31:0] i_pc,
        input  logic [1:0]  i_bp_state,
        output logic [31:0] o_instruction,
        output logic        o_valid,
        output logic        o_abort,
        output logic [31:0] o_pc,
        output logic [31:0] o_pc_plus_8,
        output logic [1:0]  o_taken,
        output logic        o_sleep
);

        logic              sleep_q;  // Parked after an abort.
        logic              skid_valid_q;
        fetch_pkg::instr_u skid_instr_q;
        logic              skid_abort_q;
        logic [31:0]       skid_pc_q;
        logic [1:0]        skid_state_q;
        fetch_pkg::instr_u src_instr;
        logic              src_abort;
        logic [31:0]       src_pc;
        logic [1:0]        src_state;

        // Skid entry goes first, it is older.
        assign src_instr = skid_valid_q ? skid_instr_q : fetch_pkg::instr_u'(i_instruction);
        assign src_abort = skid_valid_q ? skid_abort_q : i_abort;
        assign src_pc    = skid_valid_q ? skid_pc_q : i_pc;
        assign src_state = skid_valid_q ? skid_state_q : i_bp_state;

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        o_valid      <= 1'b0;
                        o_abort      <= 1'b0;
                        o_pc         <= 32'd0;
                        o_pc_plus_8  <= 32'd8;
                        sleep_q      <= 1'b0;
                        skid_valid_q <= 1'b0;
                end
                else if (i_clear_wb || (!i_stall && i_clear_alu))
                begin
                        o_valid      <= 1'b0; // Flush and wake.
                        o_abort      <= 1'b0;
                        sleep_q      <= 1'b0;
                        skid_valid_q <= 1'b0;
                end
                else if (i_stall)
                begin
                        if (i_rsp_valid) // Outputs hold, park the arrival.
                        begin
                                skid_valid_q     <= 1'b1;
                                skid_instr_q.raw <= i_instruction;
                                skid_abort_q     <= i_abort;
                                skid_pc_q        <= i_pc;
                                skid_state_q     <= i_bp_state;
                        end
                end
                else if (sleep_q)
                begin
                        o_valid      <= 1'b0; // Drop everything until a clear.
                        o_abort      <= 1'b0;
                        skid_valid_q <= 1'b0;
                end
                else if (skid_valid_q || i_rsp_valid)
                begin
                        o_valid       <= 1'b1;
                        o_abort       <= src_abort;
                        o_instruction <= src_abort ? fetch_pkg::ABORT_PAYLOAD : src_instr.raw;
                        o_pc          <= src_pc;
                        o_pc_plus_8   <= src_pc + 32'd8;
                        o_taken       <= src_state;
                        sleep_q       <= src_abort; // Abort puts the stage to sleep.
                        skid_valid_q  <= 1'b0;
                end
                else
                begin
                        o_valid <= 1'b0;
                end
        end

        assign o_sleep = sleep_q;

        a_no_wake_beat : assert property (@(posedge i_clk) disable iff (i_reset)
                $rose(o_valid) |-> !$past(sleep_q));

endmodule

/* hw/branch_predictor.sv */
`timescale 1ns/1ps

module branch_predictor (
        input  logic        i_clk,
        input  logic        i_reset,
        input  logic [31:0] i_rd_pc,     // PC being fetched.
        output logic [1:0]  o_state,     // Counter, one cycle later.
        input  logic        i_confirm,   // Execute agreed with the prediction.
        input  logic        i_mispredict,
        input  logic        i_stall,
        input  logic [31:0] i_upd_pc,
        input  logic [1:0]  i_upd_state  // State the branch was predicted with.
);

        logic [1:0]                  table_q [fetch_pkg::BP_ENTRIES];
        logic [fetch_pkg::BP_IW-1:0] rd_idx;
        logic [fetch_pkg::BP_IW-1:0] upd_idx;
        logic [1:0]                  upd_next;

        assign rd_idx  = i_rd_pc[fetch_pkg::BP_IW+1:2];  // Word address bits.
        assign upd_idx = i_upd_pc[fetch_pkg::BP_IW+1:2];

        always_comb
        begin
                if (i_mispredict)
                begin
                        case (i_upd_state) // Swing toward the other side.
                        fetch_pkg::SNT: upd_next = fetch_pkg::WNT;
                        fetch_pkg::WNT: upd_next = fetch_pkg::WT;
                        fetch_pkg::WT:  upd_next = fetch_pkg::WNT;
                        default:        upd_next = fetch_pkg::WT;
                        endcase
                end
                else
                begin
                        case (i_upd_state) // Saturate in the current direction.
                        fetch_pkg::SNT, fetch_pkg::WNT: upd_next = fetch_pkg::SNT;
                        default:                        upd_next = fetch_pkg::ST;
                        endcase
                end
        end

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        for (int i = 0; i < fetch_pkg::BP_ENTRIES; i++)
                                table_q[i] <= fetch_pkg::WNT;
                end
                else if (!i_stall && (i_confirm || i_mispredict))
                begin
                        table_q[upd_idx] <= upd_next;
                end
        end

        always_ff @(posedge i_clk)
                o_state <= table_q[rd_idx]; // Lines up with the memory response.

        a_one_update : assert property (@(posedge i_clk) disable iff (i_reset)
                !(i_confirm && i_mispredict));

endmodule

/* hw/pc_gen.sv */
`timescale 1ns/1ps

module pc_gen (
        input  logic        i_clk,
        input  logic        i_reset,
        output logic        o_req_valid,
        input  logic        i_req_ready,
        output logic [31:0] o_req_pc,
        input  logic        i_rsp_valid, // Response to the outstanding fetch.
        input  logic [31:0] i_rsp_data,
        input  logic [1:0]  i_bp_state,  // Counter for the fetched PC.
        input  logic        i_stall,
        input  logic        i_clear,     // Redirect from writeback or ALU.
        input  logic [31:0] i_clear_pc,
        input  logic        i_sleep      // Fetch stage parked on an abort.
);

        fetch_pkg::instr_u rsp_word;
        logic        req_q;     // Request raised but not yet accepted.
        logic [31:0] req_pc_q;  // PC of the request in flight.
        logic        arm_q;     // Next PC known and waiting to issue.
        logic [31:0] nxt_q;
        logic        br_taken;
        logic [31:0] br_off;
        logic [31:0] rsp_next;
        logic        have_next;
        logic [31:0] next_pc;
        logic        issue;

        assign rsp_word = i_rsp_data;

        // Predicted taken branch.
        assign br_taken = (rsp_word.br.opcode == fetch_pkg::BR_OPCODE) &&
                          (i_bp_state == fetch_pkg::WT || i_bp_state == fetch_pkg::ST);
        assign br_off   = {{6{rsp_word.br.offset[23]}}, rsp_word.br.offset, 2'b00};
        assign rsp_next = br_taken ? req_pc_q + 32'd8 + br_off : req_pc_q + 32'd4;

        // Clear beats the response and the response beats the parked PC.
        assign have_next = i_clear || i_rsp_valid || arm_q;
        assign next_pc   = i_clear ? i_clear_pc : (i_rsp_valid ? rsp_next : nxt_q);
        assign issue     = have_next && !req_q && !i_stall && !i_sleep;

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        req_q    <= 1'b0;
                        req_pc_q <= 32'd0;
                        arm_q    <= 1'b1; // First fetch from address 0.
                        nxt_q    <= 32'd0;
                end
                else
                begin
                        if (req_q && i_req_ready)
                                req_q <= 1'b0;         // Now outstanding.
                        if (issue)
                        begin
                                req_q    <= 1'b1;
                                req_pc_q <= next_pc;
                                arm_q    <= 1'b0;
                        end
                        else if (have_next)
                        begin
                                nxt_q <= next_pc;      // Park until free.
                                arm_q <= 1'b1;
                        end
                end
        end

        assign o_req_valid = req_q;
        assign o_req_pc    = req_pc_q;

        // A response only returns while no request is raised.
        a_one_outstanding : assert property (@(posedge i_clk) disable iff (i_reset)
                i_rsp_valid |-> !o_req_valid);

endmodule

/* hw/imem.sv */
`timescale 1ns/1ps

module imem (
        input  logic        i_clk,
        input  logic        i_reset,
        input  logic        i_en,        // Accepted request.
        input  logic        i_we,        // Write from the loader.
        input  logic [31:0] i_addr,      // Byte address.
        input  logic [31:0] i_wdata,
        output logic [31:0] o_rdata,
        output logic        o_abort,     // Read was out of range.
        output logic        o_rsp_valid  // Read data valid.
);

        logic [31:0]                  mem [fetch_pkg::IMEM_DEPTH];
        logic                         in_range;
        logic [fetch_pkg::IMEM_AW-1:0] idx;

        assign in_range = i_addr[31:2] < fetch_pkg::IMEM_DEPTH;
        assign idx      = i_addr[fetch_pkg::IMEM_AW+1:2];

        always_ff @(posedge i_clk)
        begin
                if (i_en && i_we && in_range)
                        mem[idx] <= i_wdata; // Stray loader writes are dropped.
                o_rdata <= in_range ? mem[idx] : fetch_pkg::ABORT_PAYLOAD;
        end

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        o_rsp_valid <= 1'b0;
                        o_abort     <= 1'b0;
                end
                else
                begin
                        o_rsp_valid <= i_en && !i_we;              // Reads only.
                        o_abort     <= i_en && !i_we && !in_range;
                end
        end

endmodule

/* hw/imem_arbiter.sv */
`timescale 1ns/1ps

module imem_arbiter (
        input  logic i_clk,
        input  logic i_reset,
        input  logic i_f_valid,  // Fetch read request.
        output logic o_f_ready,
        input  logic i_l_valid,  // Loader write request.
        output logic o_l_ready,
        output logic o_grant_ld  // Steers the memory port to the loader.
);

        logic last_ld_q; // Loader was served last.
        logic grant_ld;

        // Loader wins when alone, or when both ask and fetch went last.
        assign grant_ld   = i_l_valid && (!i_f_valid || !last_ld_q);
        assign o_l_ready  = grant_ld;
        assign o_f_ready  = i_f_valid && !grant_ld;
        assign o_grant_ld = grant_ld;

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        last_ld_q <= 1'b0; // Loader gets the first tie.
                end
                else if (o_l_ready)
                begin
                        last_ld_q <= 1'b1;
                end
                else if (o_f_ready)
                begin
                        last_ld_q <= 1'b0;
                end
        end

        // A side turned away is served next cycle if it still asks.
        a_ld_served : assert property (@(posedge i_clk) disable iff (i_reset)
                i_l_valid && !o_l_ready |=> !i_l_valid || o_l_ready);
        a_f_served : assert property (@(posedge i_clk) disable iff (i_reset)
                i_f_valid && !o_f_ready |=> !i_f_valid || o_f_ready);

endmodule

/* hw/fetch_pkg.sv */
package fetch_pkg;

        localparam int IMEM_DEPTH = 256;                // Words of instruction RAM.
        localparam int IMEM_AW    = $clog2(IMEM_DEPTH); // Word index width.
        localparam int BP_ENTRIES = 64;                 // Predictor counters.
        localparam int BP_IW      = $clog2(BP_ENTRIES); // Counter index width.

        // 2-bit saturating counter states.
        localparam logic [1:0] SNT = 2'd0; // Strongly not taken.
        localparam logic [1:0] WNT = 2'd1; // Weakly not taken.
        localparam logic [1:0] WT  = 2'd2; // Weakly taken.
        localparam logic [1:0] ST  = 2'd3; // Strongly taken.

        // Word handed to decode when a fetch aborts.
        localparam logic [31:0] ABORT_PAYLOAD = 32'd0;

        localparam logic [2:0] BR_OPCODE = 3'b101; // B and BL.

        // Branch encoding, MSB first.
        typedef struct packed {
                logic [3:0]         cond;   // Condition code.
                logic [2:0]         opcode; // 101 for a branch.
                logic               link;   // BL when set.
                logic signed [23:0] offset; // Word offset from PC+8.
        } br_t;

        // One fetched word, seen raw or as a branch.
        typedef union packed {
                logic [31:0] raw;
                br_t         br;
        } instr_u;

endpackage
